//--- Makefile
# Verilator build and run of the conversion engine testbench.

sim:
	verilator --binary --timing --assert -f list.f --top-module cvt_tb -Mdir obj_dir
	./obj_dir/Vcvt_tb | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- list.f
+incdir+source
source/cvt_pkg.sv
source/result_ram.sv
source/result_arbiter.sv
source/int_to_float_unit.sv
source/axil_cvt_regs.sv
source/cvt_top.sv
verif/cvt_checker.sv
verif/cvt_tb.sv

//--- source/axil_cvt_regs.sv
/*
 * AXI4-Lite slave of the conversion engine.
 * Writes start a unit, reads return status or a result slot.
 * Result reads go through the arbiter to the result memory.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cvt_settings.svh"

module axil_cvt_regs import cvt_pkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  axil_m2s_t   axil_in,
        output axil_s2m_t   axil_out,
        output logic        start [2],
        output cvt_op_e     op,
        output logic [31:0] operand,
        input  logic        busy [2],
        input  logic [1:0]  slot_ptr0,
        input  logic [1:0]  slot_ptr1,
        output mem_req_t    mem_req,
        input  logic        grant,
        input  logic [31:0] mem_rdata
);

        logic                   wr_unit;
        logic                   wr_start_addr;
        logic                   wr_accept;
        logic                   rd_accept;
        logic                   bvalid_q;
        logic                   rvalid_q;
        logic                   rd_pend;
        logic                   rd_sel;
        logic [2:0]             rd_slot;
        logic [31:0]            rdata_q;
        logic [31:0]            status_word;
        logic [`CVT_ADDR_W-1:0] rd_offset;

        // ====================
        // write path.
        // ====================
        // addresses below status start a unit; bit 3 picks the unit, bit 2 the op.
        assign wr_unit       = axil_in.awaddr[3];
        assign wr_start_addr = axil_in.awaddr < `CVT_STATUS_ADDR;
        assign wr_accept     = axil_in.awvalid && axil_in.wvalid && !bvalid_q &&
                               !(wr_start_addr && busy[wr_unit]);

        assign start[0] = wr_accept && wr_start_addr && !wr_unit;
        assign start[1] = wr_accept && wr_start_addr && wr_unit;
        assign op       = axil_in.awaddr[2] ? op_signed : op_unsigned;
        assign operand  = axil_in.wdata;

        // ====================
        // read path.
        // ====================
        assign rd_accept = axil_in.arvalid && !rvalid_q && !rd_pend;
        assign rd_offset = axil_in.araddr - `CVT_RESULT_BASE;

        always_comb begin
                status_word        = 32'd0;
                status_word[0]     = busy[0];
                status_word[1]     = busy[1];
                status_word[9:8]   = slot_ptr0;
                status_word[13:12] = slot_ptr1;
        end

        always_comb begin
                mem_req.req  = rd_pend;
                mem_req.we   = 1'b0;
                mem_req.addr = rd_slot;
                mem_req.data = 32'd0;
        end

        always_comb begin
                axil_out.awready = wr_accept;
                axil_out.wready  = wr_accept;
                axil_out.bresp   = 2'b00;
                axil_out.bvalid  = bvalid_q;
                axil_out.arready = rd_accept;
                axil_out.rdata   = rd_sel ? mem_rdata : rdata_q;
                axil_out.rresp   = 2'b00;
                axil_out.rvalid  = rvalid_q;
        end

        always_ff @(posedge clk) begin
                if (!rst) begin
                        bvalid_q <= 1'b0;
                        rvalid_q <= 1'b0;
                        rd_pend  <= 1'b0;
                        rd_sel   <= 1'b0;
                end else begin
                        if (wr_accept)
                                bvalid_q <= 1'b1;
                        else if (axil_in.bready)
                                bvalid_q <= 1'b0;

                        if (rd_accept) begin
                                rd_pend  <= axil_in.araddr >= `CVT_RESULT_BASE;
                                rd_sel   <= axil_in.araddr >= `CVT_RESULT_BASE;
                                rvalid_q <= axil_in.araddr < `CVT_RESULT_BASE;
                        end else if (rd_pend && grant) begin
                                rd_pend  <= 1'b0;
                                rvalid_q <= 1'b1;
                        end else if (rvalid_q && axil_in.rready) begin
                                rvalid_q <= 1'b0;
                        end
                end
        end

        // unmapped reads below the result window return zero.
        always_ff @(posedge clk) begin
                if (rd_accept) begin
                        rd_slot <= rd_offset[4:2];
                        rdata_q <= (axil_in.araddr == `CVT_STATUS_ADDR) ? status_word : 32'd0;
                end
        end

        // a started unit takes the job and turns busy on the next cycle.
        assert property (@(posedge clk) disable iff (!rst) start[0] |=> busy[0]);
        assert property (@(posedge clk) disable iff (!rst) start[1] |=> busy[1]);

endmodule

`default_nettype wire

//--- source/cvt_pkg.sv
/*
 * Types shared by the conversion engine RTL and its testbench.
 * Import with cvt_pkg::* in the module header.
 */
`default_nettype none
`include "cvt_settings.svh"

package cvt_pkg;

        typedef enum logic {
                op_unsigned = 1'b0,
                op_signed   = 1'b1
        } cvt_op_e;

        typedef enum logic [2:0] {
                st_idle,
                st_load,
                st_normalize,
                st_round,
                st_pack,
                st_write
        } unit_state_e;

        // one requester's access to the result memory.
        typedef struct packed {
                logic        req;
                logic        we;
                logic [2:0]  addr;
                logic [31:0] data;
        } mem_req_t;

        // ====================
        // AXI4-Lite channels.
        // ====================
        typedef struct packed {
                logic [`CVT_ADDR_W-1:0] awaddr;
                logic                   awvalid;
                logic [31:0]            wdata;
                logic [3:0]             wstrb;
                logic                   wvalid;
                logic                   bready;
                logic [`CVT_ADDR_W-1:0] araddr;
                logic                   arvalid;
                logic                   rready;
        } axil_m2s_t;

        typedef struct packed {
                logic        awready;
                logic        wready;
                logic [1:0]  bresp;
                logic        bvalid;
                logic        arready;
                logic [31:0] rdata;
                logic [1:0]  rresp;
                logic        rvalid;
        } axil_s2m_t;

endpackage

`default_nettype wire

//--- source/cvt_settings.svh
/*
 * Address map and sizes of the integer-to-float conversion engine.
 * Include wherever an address or a memory size is needed.
 */
`ifndef CVT_SETTINGS_SVH
`define CVT_SETTINGS_SVH

// ====================
// AXI4-Lite address map.
// ====================
`define CVT_ADDR_W      6
`define CVT_STATUS_ADDR 6'h10
`define CVT_RESULT_BASE 6'h20

// result slots per unit; the memory holds two units' worth.
`define CVT_SLOTS       4

`endif

//--- source/cvt_top.sv
/*
 * Top level of the integer-to-float conversion engine.
 * AXI4-Lite slave, two peer converters, arbiter and result memory.
 */
`timescale 1ns/1ps
`default_nettype none

module cvt_top import cvt_pkg::*; (
        input  logic      clk,
        input  logic      rst,
        input  axil_m2s_t axil_in,
        output axil_s2m_t axil_out
);

        logic        unit_start [2];
        logic        unit_busy [2];
        cvt_op_e     op;
        logic [31:0] operand;
        logic [1:0]  slot_ptr0;
        logic [1:0]  slot_ptr1;

        // arbiter inputs 0 and 1 are the units, 2 is the read path.
        mem_req_t    req_bus [3];
        logic        grant [3];
        mem_req_t    mem_bus;
        logic [31:0] mem_rdata;

        axil_cvt_regs i_axil_cvt_regs (
                .clk       (clk),
                .rst       (rst),
                .axil_in   (axil_in),
                .axil_out  (axil_out),
                .start     (unit_start),
                .op        (op),
                .operand   (operand),
                .busy      (unit_busy),
                .slot_ptr0 (slot_ptr0),
                .slot_ptr1 (slot_ptr1),
                .mem_req   (req_bus[2]),
                .grant     (grant[2]),
                .mem_rdata (mem_rdata)
        );

        // ====================
        // converters.
        // ====================
        int_to_float_unit u_unit0 (
                .clk       (clk),
                .rst       (rst),
                .start     (unit_start[0]),
                .op        (op),
                .operand   (operand),
                .slot_base (1'b0),
                .busy      (unit_busy[0]),
                .slot_ptr  (slot_ptr0),
                .mem_req   (req_bus[0]),
                .grant     (grant[0])
        );

        int_to_float_unit u_unit1 (
                .clk       (clk),
                .rst       (rst),
                .start     (unit_start[1]),
                .op        (op),
                .operand   (operand),
                .slot_base (1'b1),
                .busy      (unit_busy[1]),
                .slot_ptr  (slot_ptr1),
                .mem_req   (req_bus[1]),
                .grant     (grant[1])
        );

        result_arbiter i_result_arbiter (
                .clk     (clk),
                .rst     (rst),
                .req_in  (req_bus),
                .grant   (grant),
                .mem_out (mem_bus)
        );

        result_ram i_result_ram (
                .clk    (clk),
                .mem_in (mem_bus),
                .rdata  (mem_rdata)
        );

endmodule

`default_nettype wire

//--- source/int_to_float_unit.sv
/*
 * Sequential 32-bit integer to single-precision float converter.
 * Pulse start with an operand and opcode; the result is written to
 * the result memory through the arbiter, then busy falls.
 */
`timescale 1ns/1ps
`default_nettype none

module int_to_float_unit import cvt_pkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  logic        start,
        input  cvt_op_e     op,
        input  logic [31:0] operand,
        input  logic        slot_base,
        output logic        busy,
        output logic [1:0]  slot_ptr,
        output mem_req_t    mem_req,
        input  logic        grant
);

        unit_state_e state;

        logic [31:0] operand_q;
        cvt_op_e     op_q;
        logic        negate;
        logic [31:0] magnitude;

        logic        sign;
        logic [31:0] value;
        logic [7:0]  exp;
        logic [23:0] mant;
        logic        guard;
        logic        rnd;
        logic        sticky;
        logic [31:0] result;

        assign negate    = (op_q == op_signed) && operand_q[31];
        assign magnitude = negate ? -operand_q : operand_q;
        assign busy      = (state != st_idle);

        always_comb begin
                mem_req.req  = (state == st_write);
                mem_req.we   = 1'b1;
                mem_req.addr = {slot_base, slot_ptr};
                mem_req.data = result;
        end

        // ====================
        // control state.
        // ====================
        always_ff @(posedge clk) begin
                if (!rst) begin
                        state    <= st_idle;
                        slot_ptr <= 2'd0;
                end else begin
                        case (state)
                        st_idle:
                                if (start)
                                        state <= st_load;
                        st_load:
                                state <= (operand_q == 32'd0) ? st_pack : st_normalize;
                        st_normalize:
                                if (value[31])
                                        state <= st_round;
                        st_round:
                                state <= st_pack;
                        st_pack:
                                state <= st_write;
                        st_write:
                                if (grant) begin
                                        slot_ptr <= slot_ptr + 2'd1;
                                        state    <= st_idle;
                                end
                        default:
                                state <= st_idle;
                        endcase
                end
        end

        // ====================
        // datapath.
        // ====================
        always_ff @(posedge clk) begin
                case (state)
                st_idle:
                        if (start) begin
                                operand_q <= operand;
                                op_q      <= op;
                        end
                st_load: begin
                        sign  <= negate;
                        value <= magnitude;
                        exp   <= 8'd31;
                        // a zero operand gets exponent -127, which packs to an all-zero word.
                        if (operand_q == 32'd0) begin
                                mant <= 24'd0;
                                exp  <= 8'd129;
                        end
                end
                st_normalize:
                        if (!value[31]) begin
                                value <= value << 1;
                                exp   <= exp - 8'd1;
                        end else begin
                                mant   <= value[31:8];
                                guard  <= value[7];
                                rnd    <= value[6];
                                sticky <= |value[5:0];
                        end
                st_round:
                        // round to nearest, ties to even.
                        if (guard && (rnd || sticky || mant[0])) begin
                                mant <= mant + 24'd1;
                                if (mant == 24'hff_ffff)
                                        exp <= exp + 8'd1;
                        end
                st_pack:
                        result <= {sign, exp + 8'd127, mant[22:0]};
                default: ;
                endcase
        end

        // a pending write must not change before the arbiter takes it.
        assert property (@(posedge clk) disable iff (!rst)
                mem_req.req && !grant |=> mem_req.req && $stable(mem_req));

endmodule

`default_nettype wire

//--- source/result_arbiter.sv
/*
 * Round-robin arbiter for the single result memory port.
 * Grants are registered and last one cycle, the cycle in which the
 * winner's access is presented to the memory.
 */
`timescale 1ns/1ps
`default_nettype none

module result_arbiter import cvt_pkg::*; (
        input  logic     clk,
        input  logic     rst,
        input  mem_req_t req_in [3],
        output logic     grant [3],
        output mem_req_t mem_out
);

        logic [1:0] last;
        logic [1:0] pick;
        logic       pick_valid;

        // search starts just past the last winner.
        // a requester holding a grant is skipped while it drops req.
        always_comb begin
                int idx;
                pick_valid = 1'b0;
                pick       = last;
                for (int i = 0; i < 3; i++) begin
                        idx = int'(last) + 1 + i;
                        if (idx >= 3)
                                idx = idx - 3;
                        if (!pick_valid && req_in[idx].req && !grant[idx]) begin
                                pick_valid = 1'b1;
                                pick       = idx[1:0];
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (!rst) begin
                        for (int k = 0; k < 3; k++)
                                grant[k] <= 1'b0;
                        mem_out <= '0;
                        last    <= 2'd2;
                end else begin
                        for (int k = 0; k < 3; k++)
                                grant[k] <= pick_valid && (pick == k[1:0]);
                        mem_out <= pick_valid ? req_in[pick] : '0;
                        if (pick_valid)
                                last <= pick;
                end
        end

        assert property (@(posedge clk) disable iff (!rst)
                $onehot0({grant[2], grant[1], grant[0]}));

endmodule

`default_nettype wire

//--- source/result_ram.sv
/*
 * Result memory, one synchronous port driven by the arbiter.
 * Read data appears the cycle after a read request.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cvt_settings.svh"

module result_ram import cvt_pkg::*; (
        input  logic        clk,
        input  mem_req_t    mem_in,
        output logic [31:0] rdata
);

        // two units, each with its own block of slots.
        logic [31:0] mem [2*`CVT_SLOTS];

        always_ff @(posedge clk) begin
                if (mem_in.req) begin
                        if (mem_in.we)
                                mem[mem_in.addr] <= mem_in.data;
                        else
                                rdata <= mem[mem_in.addr];
                end
        end

endmodule

`default_nettype wire

//--- verif/cvt_checker.sv
/*
 * Passive monitor of the conversion engine's AXI4-Lite port.
 * Tracks slot pointers from accepted writes, models each conversion
 * and compares status reads, result reads and responses.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cvt_settings.svh"

module cvt_checker import cvt_pkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  axil_m2s_t   axil_in,
        input  axil_s2m_t   axil_out,
        input  logic        table_known,
        input  logic [31:0] table_value,
        output int          pass_count,
        output int          fail_count
);

        logic [1:0]             ptr [2];
        logic [1:0]             ptr_at_ar [2];
        logic [31:0]            model_exp [8];
        logic [32:0]            table_exp [8];
        logic [7:0]             written;
        logic [`CVT_ADDR_W-1:0] ar_addr;
        logic                   wr_unit;
        logic [2:0]             wr_slot;

        assign wr_unit = axil_in.awaddr[3];
        assign wr_slot = {wr_unit, ptr[wr_unit]};

        initial begin
                pass_count = 0;
                fail_count = 0;
        end

        // ====================
        // reference model.
        // ====================
        // round to nearest even on the bits shifted out below the mantissa.
        function automatic logic [31:0] to_float(input logic [31:0] x, input logic signed_op);
                logic        neg;
                logic [31:0] mag;
                logic [31:0] mant;
                logic [31:0] rem;
                logic [31:0] half;
                logic [7:0]  e;
                int          top;
                int          shift;
                neg = signed_op && x[31];
                mag = neg ? -x : x;
                if (mag == 32'd0)
                        return 32'd0;
                top = 0;
                for (int b = 0; b < 32; b++)
                        if (mag[b])
                                top = b;
                e = 8'(top + 127);
                if (top <= 23)
                        return {neg, e, 23'(mag << (23 - top))};
                shift = top - 23;
                mant  = mag >> shift;
                rem   = mag & ((32'd1 << shift) - 32'd1);
                half  = 32'd1 << (shift - 1);
                if (rem > half || (rem == half && mant[0]))
                        mant = mant + 32'd1;
                // carry out of the mantissa bumps the exponent.
                if (mant[24]) begin
                        mant = mant >> 1;
                        e    = e + 8'd1;
                end
                return {neg, e, mant[22:0]};
        endfunction

        // an idle unit has written all its results, so its pointer is settled.
        task automatic check_status(input logic [31:0] rdata);
                for (int k = 0; k < 2; k++) begin
                        if (!rdata[k] && rdata[8 + 4 * k +: 2] != ptr_at_ar[k]) begin
                                $display("Fail slot_ptr%0d expected %h actual %h",
                                         k, ptr_at_ar[k], rdata[8 + 4 * k +: 2]);
                                fail_count++;
                        end
                end
        endtask

        task automatic check_result(input logic [31:0] rdata);
                logic [2:0] slot;
                slot = ar_addr[4:2];
                if (!written[slot]) begin
                        $display("slot %0d was read before any conversion was written to it",
                                 slot);
                        fail_count++;
                end else if (rdata != model_exp[slot]) begin
                        $display("Fail rdata slot %0d expected %h actual %h",
                                 slot, model_exp[slot], rdata);
                        fail_count++;
                end else if (table_exp[slot][32] && rdata != table_exp[slot][31:0]) begin
                        $display("Fail rdata slot %0d expected %h actual %h",
                                 slot, table_exp[slot][31:0], rdata);
                        fail_count++;
                end else begin
                        $display("ok   slot %0d rdata %h", slot, rdata);
                        pass_count++;
                end
        endtask

        // ====================
        // bus watch.
        // ====================
        always @(posedge clk) begin
                if (!rst) begin
                        ptr[0]  <= 2'd0;
                        ptr[1]  <= 2'd0;
                        written <= 8'd0;
                end else begin
                        // awready and wready rise together.
                        if (axil_out.awready != axil_out.wready) begin
                                $display("Fail wready expected %h actual %h",
                                         axil_out.awready, axil_out.wready);
                                fail_count++;
                        end
                        if (axil_out.bvalid && axil_in.bready && axil_out.bresp != 2'b00) begin
                                $display("Fail bresp expected %h actual %h",
                                         2'b00, axil_out.bresp);
                                fail_count++;
                        end
                        // snapshot before a write in the same cycle moves a pointer.
                        if (axil_in.arvalid && axil_out.arready) begin
                                ar_addr      <= axil_in.araddr;
                                ptr_at_ar[0] <= ptr[0];
                                ptr_at_ar[1] <= ptr[1];
                        end
                        if (axil_in.awvalid && axil_out.awready) begin
                                model_exp[wr_slot] <= to_float(axil_in.wdata, axil_in.awaddr[2]);
                                table_exp[wr_slot] <= {table_known, table_value};
                                written[wr_slot]   <= 1'b1;
                                ptr[wr_unit]       <= ptr[wr_unit] + 2'd1;
                        end
                        if (axil_out.rvalid && axil_in.rready) begin
                                if (axil_out.rresp != 2'b00) begin
                                        $display("Fail rresp expected %h actual %h",
                                                 2'b00, axil_out.rresp);
                                        fail_count++;
                                end
                                if (ar_addr == `CVT_STATUS_ADDR)
                                        check_status(axil_out.rdata);
                                else if (ar_addr >= `CVT_RESULT_BASE)
                                        check_result(axil_out.rdata);
                        end
                end
        end

endmodule

`default_nettype wire

//--- verif/cvt_tb.sv
/*
 * Testbench of the integer-to-float conversion engine.
 * Applies a table of conversions over AXI4-Lite, up to four in flight,
 * and leaves the comparing to the checker.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cvt_settings.svh"

module cvt_tb import cvt_pkg::*; ();

        typedef struct packed {
                logic        unit;
                cvt_op_e     op;
                logic [31:0] operand;
                logic        known;
                logic [31:0] expected;
        } test_entry_t;

        logic        clk;
        logic        rst;
        axil_m2s_t   axil_in;
        axil_s2m_t   axil_out;
        logic        table_known;
        logic [31:0] table_value;
        int          pass_count;
        int          fail_count;
        int          cycle_count = 0;
        int          cycle_limit = 0;
        test_entry_t tests [$];
        logic [1:0]  tb_ptr [2];
        logic        pending_unit [$];
        logic [2:0]  pending_slot [$];

        cvt_top i_cvt_top (
                .clk      (clk),
                .rst      (rst),
                .axil_in  (axil_in),
                .axil_out (axil_out)
        );

        cvt_checker i_cvt_checker (
                .clk         (clk),
                .rst         (rst),
                .axil_in     (axil_in),
                .axil_out    (axil_out),
                .table_known (table_known),
                .table_value (table_value),
                .pass_count  (pass_count),
                .fail_count  (fail_count)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        always @(posedge clk)
                cycle_count <= cycle_count + 1;

        initial begin
                wait (cycle_limit > 0 && cycle_count >= cycle_limit);
                $display("timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Something failed");
                $finish;
        end

        // ====================
        // table building.
        // ====================
        function automatic void add_directed(input logic unit, input cvt_op_e op,
                                             input logic [31:0] operand,
                                             input logic [31:0] expected);
                tests.push_back({unit, op, operand, 1'b1, expected});
        endfunction

        function automatic void add_random(input logic unit, input cvt_op_e op);
                tests.push_back({unit, op, $urandom(), 1'b0, 32'd0});
        endfunction

        // ====================
        // AXI4-Lite master.
        // ====================
        // ready is sampled at the falling edge, where it is settled.
        task automatic axi_write(input logic [`CVT_ADDR_W-1:0] addr, input logic [31:0] data);
                axil_in.awaddr  = addr;
                axil_in.wdata   = data;
                axil_in.awvalid = 1'b1;
                axil_in.wvalid  = 1'b1;
                axil_in.bready  = 1'b1;
                @(negedge clk);
                while (!axil_out.awready)
                        @(negedge clk);
                @(posedge clk);
                #1;
                axil_in.awvalid = 1'b0;
                axil_in.wvalid  = 1'b0;
                while (!axil_out.bvalid)
                        @(negedge clk);
                @(posedge clk);
                #1;
                axil_in.bready = 1'b0;
        endtask

        task automatic axi_read(input logic [`CVT_ADDR_W-1:0] addr, output logic [31:0] data);
                axil_in.araddr  = addr;
                axil_in.arvalid = 1'b1;
                axil_in.rready  = 1'b1;
                @(negedge clk);
                while (!axil_out.arready)
                        @(negedge clk);
                @(posedge clk);
                #1;
                axil_in.arvalid = 1'b0;
                while (!axil_out.rvalid)
                        @(negedge clk);
                data = axil_out.rdata;
                @(posedge clk);
                #1;
                axil_in.rready = 1'b0;
        endtask

        task automatic wait_idle(input logic unit);
                logic [31:0] status;
                axi_read(`CVT_STATUS_ADDR, status);
                while (status[unit])
                        axi_read(`CVT_STATUS_ADDR, status);
        endtask

        // results are read back in write order once each unit is idle.
        task automatic drain_pending();
                logic [2:0]  slot;
                logic [31:0] word;
                while (pending_unit.size() > 0) begin
                        slot = pending_slot.pop_front();
                        wait_idle(pending_unit.pop_front());
                        axi_read(`CVT_RESULT_BASE + {slot, 2'b00}, word);
                end
        endtask

        initial begin
                void'($urandom(32'h5379_6bd3));
                axil_in     = '0;
                table_known = 1'b0;
                table_value = 32'd0;
                tb_ptr[0]   = 2'd0;
                tb_ptr[1]   = 2'd0;
                rst         = 1'b0;

                // long conversions first, so the next write to the unit stalls.
                add_directed(1'b0, op_unsigned, 32'h0000_0001, 32'h3f80_0000);
                add_directed(1'b1, op_unsigned, 32'hffff_ffff, 32'h4f80_0000);
                add_directed(1'b0, op_unsigned, 32'h0000_0000, 32'h0000_0000);
                add_directed(1'b1, op_signed,   32'hffff_ffff, 32'hbf80_0000);
                add_directed(1'b0, op_unsigned, 32'h0000_0100, 32'h4380_0000);
                add_directed(1'b1, op_signed,   32'h8000_0000, 32'hcf00_0000);
                add_directed(1'b0, op_unsigned, 32'h8000_0000, 32'h4f00_0000);
                add_directed(1'b1, op_signed,   32'hffff_ff9c, 32'hc2c8_0000);
                // ties to even, and a mantissa carry into the exponent.
                add_directed(1'b0, op_unsigned, 32'h0100_0001, 32'h4b80_0000);
                add_directed(1'b1, op_unsigned, 32'h0100_0003, 32'h4b80_0002);
                add_directed(1'b0, op_unsigned, 32'h0100_0002, 32'h4b80_0001);
                add_directed(1'b1, op_unsigned, 32'h7fff_ffc0, 32'h4f00_0000);
                add_directed(1'b0, op_signed,   32'h0000_0003, 32'h4040_0000);
                add_directed(1'b1, op_unsigned, 32'h00ff_ffff, 32'h4b7f_ffff);
                add_random(1'b0, op_unsigned);
                add_random(1'b1, op_signed);
                add_random(1'b0, op_signed);
                add_random(1'b1, op_unsigned);
                add_random(1'b0, op_unsigned);
                add_random(1'b1, op_signed);
                cycle_limit = tests.size() * 80 + 200;

                repeat (8) @(posedge clk);
                #1;
                rst = 1'b1;

                foreach (tests[i]) begin
                        table_known = tests[i].known;
                        table_value = tests[i].expected;
                        axi_write({2'b00, tests[i].unit, tests[i].op, 2'b00}, tests[i].operand);
                        pending_unit.push_back(tests[i].unit);
                        pending_slot.push_back({tests[i].unit, tb_ptr[tests[i].unit]});
                        tb_ptr[tests[i].unit] = tb_ptr[tests[i].unit] + 2'd1;
                        if (pending_unit.size() == 4 || i == tests.size() - 1)
                                drain_pending();
                end

                repeat (4) @(posedge clk);
                $display("tests passed %0d, failed %0d", pass_count, fail_count);
                if (fail_count == 0 && pass_count == tests.size())
                        $display("Everything OK");
                else
                        $display("Something failed");
                $finish;
        end

endmodule

`default_nettype wire
